/* vlog.f */
+incdir+common
common/duc_pkg.sv
verilog/duc_regs.sv
duc/duc_interp.sv
duc/duc_nco.sv
duc/duc_mixer.sv
verilog/duc_top.sv
verif/duc_chk.sv
verif/duc_tb.sv

/* verif/duc_tb.sv */
//////////////////////////////////////////////////
// Testbench for the DUC top level
// Drives APB and the sample stream against a model
//////////////////////////////////////////////////

module duc_tb;

  localparam int TIMEOUT_CYCLES = 2 * (16 * 1 + 40 * 4 + 40 * 4 + 22 * 4 + 8 * 1) + 200;
  localparam duc_pkg::phase_t MIX_INC   = 32'h0530_0000;
  localparam duc_pkg::scale_t MIX_SCALE = 16'd12000;
  localparam logic [31:0]     EXP_ID    = 32'hD0C0_0001;

  logic ce_clk = 1'b0;
  logic i_reset, i_psel, i_penable, i_pwrite;
  duc_pkg::apb_addr_t i_paddr;
  logic [31:0] i_pwdata, o_prdata;
  logic o_pready, o_pslverr;
  duc_pkg::sample_t i_tdata, o_tdata;
  logic i_tvalid, o_tready, o_tvalid, i_tready;

  int sine_tab [64];
  duc_pkg::sample_t in_q[$];
  duc_pkg::sample_t exp_q[$];
  duc_pkg::sample_t gen_q[$];
  duc_pkg::phase_t ref_phase = '0;
  logic backpressure = 1'b0;
  logic checking = 1'b1;
  logic in_taken, out_taken;
  int errors = 0;
  int outputs = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int test_base = 0;
  int cycles = 0;

  duc_top dut0 (
    .ce_clk(ce_clk), .i_reset(i_reset),
    .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
    .i_paddr(i_paddr), .i_pwdata(i_pwdata),
    .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
    .i_tdata(i_tdata), .i_tvalid(i_tvalid), .o_tready(o_tready),
    .o_tdata(o_tdata), .o_tvalid(o_tvalid), .i_tready(i_tready)
  );

  always #50 ce_clk = ~ce_clk;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic duc_pkg::comp_t sat16(input longint v);
    if (v > 32767) return duc_pkg::comp_t'(32767);
    if (v < -32768) return duc_pkg::comp_t'(-32768);
    return duc_pkg::comp_t'(v);
  endfunction

  // Rotate by the table entries at this phase, then gain and clamp
  function automatic duc_pkg::sample_t ref_mix(input duc_pkg::sample_t s,
                                               input duc_pkg::phase_t ph,
                                               input duc_pkg::scale_t g);
    int idx;
    longint si, sq, sn, cs, gl, mi, mq;
    idx = ph[31:26];
    sn  = sine_tab[idx];
    cs  = sine_tab[(idx + 16) % 64];
    si  = $signed(s[31:16]);
    sq  = $signed(s[15:0]);
    gl  = g;
    mi  = (si * cs - sq * sn) >>> 15;
    mq  = (si * sn + sq * cs) >>> 15;
    return {sat16((mi * gl) >>> 14), sat16((mq * gl) >>> 14)};
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks and APB access
  //////////////////////////////////////////////////

  task automatic check_sample(input duc_pkg::sample_t got, input duc_pkg::sample_t exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: output %0d is %h, expected %h", $time, outputs, got, exp);
    end
  endtask

  task automatic check_reg(input string what, input logic [31:0] got, input logic [31:0] exp,
                           input logic got_err, input logic exp_err);
    if (got !== exp || got_err !== exp_err) begin
      errors++;
      $display("Mismatch at %0t: %s gave %h pslverr %b, expected %h pslverr %b",
               $time, what, got, got_err, exp, exp_err);
    end
  endtask

  task automatic apb_access(input logic wr, input duc_pkg::apb_addr_t addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(posedge ce_clk);
    #10;
    i_psel    = 1'b1;
    i_pwrite  = wr;
    i_paddr   = addr;
    i_pwdata  = wdata;
    i_penable = 1'b0;
    @(posedge ce_clk);
    #10;
    i_penable = 1'b1;
    // No wait states so the response is settled mid-cycle
    @(negedge ce_clk);
    rdata = o_prdata;
    err   = o_pslverr;
    @(posedge ce_clk);
    #10;
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
  endtask

  task automatic reg_read(input duc_pkg::apb_addr_t addr, input logic [31:0] exp,
                          input logic exp_err, input string what);
    logic [31:0] rd;
    logic err;
    apb_access(1'b0, addr, 32'd0, rd, err);
    check_reg(what, rd, exp, err, exp_err);
  endtask

  // Only the error response is meaningful on a write
  task automatic reg_write(input duc_pkg::apb_addr_t addr, input logic [31:0] data,
                           input logic exp_err, input string what);
    logic [31:0] rd;
    logic err;
    apb_access(1'b1, addr, data, rd, err);
    check_reg(what, 32'd0, 32'd0, err, exp_err);
  endtask

  task automatic configure(input duc_pkg::phase_t inc, input duc_pkg::scale_t g,
                           input duc_pkg::interp_t f);
    reg_write(duc_pkg::REG_PHASE_INC, inc, 1'b0, "phase_inc write");
    reg_write(duc_pkg::REG_SCALE, {16'd0, g}, 1'b0, "scale write");
    reg_write(duc_pkg::REG_INTERP, {24'd0, f}, 1'b0, "interp write");
  endtask

  //////////////////////////////////////////////////
  // Stream stimulus and expected data
  //////////////////////////////////////////////////

  task automatic fill_random(input int n);
    gen_q.delete();
    repeat (n) gen_q.push_back($urandom());
  endtask

  // Each input gives f outputs at successive phases
  task automatic queue_samples(input duc_pkg::phase_t inc, input duc_pkg::scale_t g,
                               input duc_pkg::interp_t f);
    int reps;
    reps = (f == 0) ? 1 : f;
    foreach (gen_q[k]) begin
      for (int r = 0; r < reps; r++) begin
        exp_q.push_back(ref_mix(gen_q[k], ref_phase, g));
        ref_phase += inc;
      end
      in_q.push_back(gen_q[k]);
    end
  endtask

  task automatic wait_done();
    while (in_q.size() != 0 || exp_q.size() != 0) begin
      @(posedge ce_clk);
    end
    repeat (4) @(posedge ce_clk);
  endtask

  task automatic end_test(input string name);
    if (errors == test_base) begin
      tests_passed++;
      $display("Test %s passed", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, errors - test_base);
    end
    test_base = errors;
  endtask

  // Input feeder with random gaps
  always begin
    @(negedge ce_clk);
    in_taken = i_tvalid & o_tready;
    @(posedge ce_clk);
    #10;
    if (in_taken) begin
      void'(in_q.pop_front());
      i_tvalid = 1'b0;
    end
    if (!i_tvalid && in_q.size() != 0 && $urandom_range(3) != 0) begin
      i_tdata  = in_q[0];
      i_tvalid = 1'b1;
    end
  end

  // Output compare and back-pressure
  always begin
    @(negedge ce_clk);
    out_taken = o_tvalid & i_tready;
    if (out_taken && checking) begin
      outputs++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("Unexpected output %h at time %0t with nothing expected", o_tdata, $time);
      end else begin
        check_sample(o_tdata, exp_q.pop_front());
      end
    end
    @(posedge ce_clk);
    #10;
    i_tready = backpressure ? ($urandom_range(3) != 0) : 1'b1;
  end

  always @(posedge ce_clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    real v;
    void'($urandom(32'hdf0f4f65));
    for (int k = 0; k < 64; k++) begin
      v = 32767.0 * $sin(2.0 * 3.14159265358979 * k / 64.0);
      sine_tab[k] = (v < 0.0) ? $rtoi(v - 0.5) : $rtoi(v + 0.5);
    end
    i_reset   = 1'b1;
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
    i_paddr   = '0;
    i_pwdata  = '0;
    i_tdata   = '0;
    i_tvalid  = 1'b0;
    i_tready  = 1'b1;
    repeat (4) @(posedge ce_clk);
    #10;
    i_reset = 1'b0;

    reg_read(duc_pkg::REG_SCALE, 32'd16384, 1'b0, "scale after reset");
    reg_read(duc_pkg::REG_INTERP, 32'd0, 1'b0, "interp after reset");
    configure(32'h1234_5678, 16'h5000, 8'd3);
    reg_read(duc_pkg::REG_PHASE_INC, 32'h1234_5678, 1'b0, "phase_inc readback");
    reg_read(duc_pkg::REG_SCALE, 32'h0000_5000, 1'b0, "scale readback");
    reg_read(duc_pkg::REG_INTERP, 32'd3, 1'b0, "interp readback");
    reg_read(duc_pkg::REG_ID, EXP_ID, 1'b0, "id read");
    reg_read(duc_pkg::REG_CLEAR, 32'd0, 1'b0, "clear readback");
    reg_read(8'h14, 32'd0, 1'b1, "unmapped read");
    reg_write(8'h20, 32'hffff_ffff, 1'b1, "unmapped write");
    reg_write(duc_pkg::REG_ID, 32'd0, 1'b1, "id write");
    reg_read(duc_pkg::REG_ID, EXP_ID, 1'b0, "id after write");
    end_test("register access");

    configure(32'd0, 16'd16384, 8'd1);
    fill_random(16);
    queue_samples(32'd0, 16'd16384, 8'd1);
    wait_done();
    end_test("pass-through");

    configure(MIX_INC, MIX_SCALE, 8'd4);
    fill_random(40);
    queue_samples(MIX_INC, MIX_SCALE, 8'd4);
    wait_done();
    end_test("interpolation and mixing");

    // Same samples from phase 0 with a stalling sink
    reg_write(duc_pkg::REG_CLEAR, 32'd1, 1'b0, "clear write");
    repeat (2) @(posedge ce_clk);
    ref_phase    = '0;
    backpressure = 1'b1;
    queue_samples(MIX_INC, MIX_SCALE, 8'd4);
    wait_done();
    backpressure = 1'b0;
    end_test("back-pressure");

    // Clear while the last sample is still in the mixer
    checking = 1'b0;
    fill_random(10);
    queue_samples(MIX_INC, MIX_SCALE, 8'd4);
    while (in_q.size() != 0) @(posedge ce_clk);
    reg_write(duc_pkg::REG_CLEAR, 32'd1, 1'b0, "clear write");
    repeat (4) @(posedge ce_clk);
    exp_q.delete();
    ref_phase = '0;
    checking  = 1'b1;
    fill_random(12);
    queue_samples(MIX_INC, MIX_SCALE, 8'd4);
    wait_done();
    end_test("clear");

    configure(32'h0400_0000, 16'hffff, 8'd1);
    gen_q.delete();
    for (int k = 0; k < 8; k++) begin
      gen_q.push_back({(k[0] ? 16'h8000 : 16'h7fff), (k[1] ? 16'h8000 : 16'h7fff)});
    end
    queue_samples(32'h0400_0000, 16'hffff, 8'd1);
    wait_done();
    end_test("saturation");

    $display("Tests passed %0d, failed %0d, assertion failures %0d",
             tests_passed, tests_failed, dut0.chk0.assert_fails);
    if (tests_failed == 0 && errors == 0 && dut0.chk0.assert_fails == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* verif/duc_chk.sv */
//////////////////////////////////////////////////
// Protocol assertions on the DUC top-level ports
// Bound into every duc_top instance
//////////////////////////////////////////////////

module duc_chk (
  input logic             ce_clk,
  input logic             i_reset,
  input logic             i_clear,
  input logic             i_psel,
  input logic             i_penable,
  input logic             o_pready,
  input logic             o_pslverr,
  input duc_pkg::sample_t o_tdata,
  input logic             o_tvalid,
  input logic             i_tready
);

  int assert_fails = 0;

  // A clear pulse may drop a held output
  out_hold: assert property (@(posedge ce_clk) disable iff (i_reset)
    o_tvalid && !i_tready && !i_clear |=> o_tvalid && $stable(o_tdata))
    else begin
      $error("output stream changed or dropped before its transfer");
      assert_fails++;
    end

  reset_idle: assert property (@(posedge ce_clk) i_reset |=> !o_tvalid)
    else begin
      $error("o_tvalid high in the cycle after reset");
      assert_fails++;
    end

  // Zero wait state slave
  pready_high: assert property (@(posedge ce_clk) o_pready)
    else begin
      $error("o_pready went low");
      assert_fails++;
    end

  pslverr_access: assert property (@(posedge ce_clk) o_pslverr |-> i_psel && i_penable)
    else begin
      $error("o_pslverr high outside an access phase");
      assert_fails++;
    end

endmodule

bind duc_top duc_chk chk0 (
  .ce_clk(ce_clk), .i_reset(i_reset), .i_clear(clear),
  .i_psel(i_psel), .i_penable(i_penable), .o_pready(o_pready), .o_pslverr(o_pslverr),
  .o_tdata(o_tdata), .o_tvalid(o_tvalid), .i_tready(i_tready)
);

/* verilog/duc_top.sv */
//////////////////////////////////////////////////
// DUC top level, APB settings plus the chain
// interpolator, NCO and mixer on ce_clk
//////////////////////////////////////////////////

module duc_top (
  input  logic                ce_clk,
  input  logic                i_reset,
  // APB
  input  logic                i_psel,
  input  logic                i_penable,
  input  logic                i_pwrite,
  input  duc_pkg::apb_addr_t  i_paddr,
  input  logic [31:0]         i_pwdata,
  output logic [31:0]         o_prdata,
  output logic                o_pready,
  output logic                o_pslverr,
  // Input stream
  input  duc_pkg::sample_t    i_tdata,
  input  logic                i_tvalid,
  output logic                o_tready,
  // Output stream
  output duc_pkg::sample_t    o_tdata,
  output logic                o_tvalid,
  input  logic                i_tready
);

  duc_pkg::phase_t  phase_inc;
  duc_pkg::scale_t  scale;
  duc_pkg::interp_t interp;
  logic             clear;

  duc_pkg::sample_t interp_sample;
  logic             interp_valid;
  logic             mixer_ready;
  logic             mixer_advance;
  duc_pkg::comp_t   nco_cos;
  duc_pkg::comp_t   nco_sin;

  duc_regs regs0 (
    .i_clk_ce(ce_clk), .i_reset(i_reset),
    .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
    .i_paddr(i_paddr), .i_pwdata(i_pwdata),
    .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
    .o_phase_inc(phase_inc), .o_scale(scale), .o_interp(interp), .o_clear(clear)
  );

  //////////////////////////////////////////////////
  // Up-conversion chain
  //////////////////////////////////////////////////

  duc_interp interp0 (
    .ce_clk(ce_clk), .i_reset(i_reset), .i_clear(clear), .i_interp(interp),
    .i_tdata(i_tdata), .i_tvalid(i_tvalid), .o_tready(o_tready),
    .o_sample(interp_sample), .o_valid(interp_valid), .i_ready(mixer_ready)
  );

  duc_nco nco0 (
    .ce_clk(ce_clk), .i_reset(i_reset), .i_clear(clear),
    .i_phase_inc(phase_inc), .i_advance(mixer_advance),
    .o_cos(nco_cos), .o_sin(nco_sin)
  );

  duc_mixer mixer0 (
    .ce_clk(ce_clk), .i_reset(i_reset), .i_clear(clear), .i_scale(scale),
    .i_sample(interp_sample), .i_valid(interp_valid), .o_ready(mixer_ready),
    .i_cos(nco_cos), .i_sin(nco_sin), .o_advance(mixer_advance),
    .o_tdata(o_tdata), .o_tvalid(o_tvalid), .i_tready(i_tready)
  );

endmodule

/* duc/duc_mixer.sv */
//////////////////////////////////////////////////
// Complex mixer with gain and saturation
// Two stages, stalled together by the output port
//////////////////////////////////////////////////

module duc_mixer (
  input  logic              ce_clk,
  input  logic              i_reset,
  input  logic              i_clear,
  input  duc_pkg::scale_t   i_scale,
  // Samples from the interpolator
  input  duc_pkg::sample_t  i_sample,
  input  logic              i_valid,
  output logic              o_ready,
  // NCO
  input  duc_pkg::comp_t    i_cos,
  input  duc_pkg::comp_t    i_sin,
  output logic              o_advance,
  // Output stream
  output duc_pkg::sample_t  o_tdata,
  output logic              o_tvalid,
  input  logic              i_tready
);

  // Rotated value after the 15-bit shift
  localparam int MIX_W  = 18;
  localparam int PROD_W = MIX_W + 17;

  localparam logic signed [PROD_W-15:0] SAT_MAX = 32767;
  localparam logic signed [PROD_W-15:0] SAT_MIN = -32768;

  typedef logic signed [MIX_W-1:0] mix_t;

  // Gain with 14 fractional bits, then clamp to 16 bits
  function automatic duc_pkg::comp_t scale_sat(input mix_t v, input duc_pkg::scale_t g);
    logic signed [PROD_W-1:0]  prod;
    logic signed [PROD_W-15:0] shifted;
    prod    = v * $signed({1'b0, g});
    shifted = prod[PROD_W-1:14];
    if (shifted > SAT_MAX) begin
      return duc_pkg::comp_t'(SAT_MAX);
    end else if (shifted < SAT_MIN) begin
      return duc_pkg::comp_t'(SAT_MIN);
    end
    return duc_pkg::comp_t'(shifted);
  endfunction

  duc_pkg::comp_t in_i;
  duc_pkg::comp_t in_q;

  logic signed [31:0] p_ic, p_qs, p_is, p_qc;
  logic signed [32:0] sum_i, sum_q;

  mix_t s1_i, s1_q;
  logic s1_valid;
  logic stage_en;

  //////////////////////////////////////////////////
  // Stall control
  //////////////////////////////////////////////////

  // Whole pipe moves when the output slot is free or leaving
  assign stage_en  = ~o_tvalid | i_tready;
  assign o_ready   = stage_en;
  assign o_advance = i_valid & stage_en;

  //////////////////////////////////////////////////
  // Stage 1, complex rotation
  //////////////////////////////////////////////////

  assign in_i = i_sample[31:16];
  assign in_q = i_sample[15:0];

  assign p_ic = in_i * i_cos;
  assign p_qs = in_q * i_sin;
  assign p_is = in_i * i_sin;
  assign p_qc = in_q * i_cos;

  assign sum_i = p_ic - p_qs;
  assign sum_q = p_is + p_qc;

  always_ff @(posedge ce_clk) begin
    if (i_reset | i_clear) begin
      s1_valid <= 1'b0;
    end else if (stage_en) begin
      s1_valid <= i_valid;
    end
  end

  // Arithmetic shift right by 15
  always_ff @(posedge ce_clk) begin
    if (stage_en) begin
      s1_i <= sum_i[32:15];
      s1_q <= sum_q[32:15];
    end
  end

  //////////////////////////////////////////////////
  // Stage 2, gain and output register
  //////////////////////////////////////////////////

  always_ff @(posedge ce_clk) begin
    if (i_reset | i_clear) begin
      o_tvalid <= 1'b0;
    end else if (stage_en) begin
      o_tvalid <= s1_valid;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (stage_en) begin
      o_tdata <= {scale_sat(s1_i, i_scale), scale_sat(s1_q, i_scale)};
    end
  end

endmodule

/* duc/duc_nco.sv */
//////////////////////////////////////////////////
// NCO, phase accumulator with sine table lookup
// Steps once per sample entering the mixer
//////////////////////////////////////////////////

module duc_nco (
  input  logic              ce_clk,
  input  logic              i_reset,
  input  logic              i_clear,
  input  duc_pkg::phase_t   i_phase_inc,
  input  logic              i_advance,
  output duc_pkg::comp_t    o_cos,
  output duc_pkg::comp_t    o_sin
);

  localparam int PHASE_W = $bits(duc_pkg::phase_t);
  localparam int IDX_W   = $clog2(duc_pkg::LUT_DEPTH);
  localparam int QUARTER = duc_pkg::LUT_DEPTH / 4;

`include "duc_sine_lut.svh"

  duc_pkg::phase_t  phase;
  logic [IDX_W-1:0] sin_idx;
  logic [IDX_W-1:0] cos_idx;

  //////////////////////////////////////////////////
  // Phase accumulator
  //////////////////////////////////////////////////

  // Wraps naturally at 2^32
  always_ff @(posedge ce_clk) begin
    if (i_reset | i_clear) begin
      phase <= '0;
    end else if (i_advance) begin
      phase <= phase + i_phase_inc;
    end
  end

  //////////////////////////////////////////////////
  // Table lookup
  //////////////////////////////////////////////////

  // Top phase bits select the entry
  assign sin_idx = phase[PHASE_W-1 -: IDX_W];

  // Cosine leads by a quarter period, index wraps mod 64
  assign cos_idx = sin_idx + IDX_W'(QUARTER);

  assign o_sin = SINE_LUT[sin_idx];
  assign o_cos = SINE_LUT[cos_idx];

endmodule

/* duc/duc_interp.sv */
//////////////////////////////////////////////////
// Hold interpolator, repeats each input sample
// interp times toward the mixer
//////////////////////////////////////////////////

module duc_interp (
  input  logic               ce_clk,
  input  logic               i_reset,
  input  logic               i_clear,
  input  duc_pkg::interp_t   i_interp,
  // Input stream
  input  duc_pkg::sample_t   i_tdata,
  input  logic               i_tvalid,
  output logic               o_tready,
  // Repeated samples to the mixer
  output duc_pkg::sample_t   o_sample,
  output logic               o_valid,
  input  logic               i_ready
);

  duc_pkg::interp_state_t state;
  duc_pkg::sample_t       hold_q;
  duc_pkg::interp_t       count;
  duc_pkg::interp_t       factor;

  logic last_rep;
  logic rep_done;
  logic take_in;

  // A factor of 0 behaves as 1
  assign factor = (i_interp == '0) ? duc_pkg::interp_t'(1) : i_interp;

  assign last_rep = (count == duc_pkg::interp_t'(1));
  assign rep_done = o_valid & i_ready;

  assign o_valid  = (state == duc_pkg::HOLD);
  assign o_sample = hold_q;

  // New sample when empty, or as the last repeat leaves
  assign o_tready = ~i_clear & ((state == duc_pkg::IDLE) | (rep_done & last_rep));
  assign take_in  = i_tvalid & o_tready;

  //////////////////////////////////////////////////
  // FSM and repeat counter
  //////////////////////////////////////////////////

  always_ff @(posedge ce_clk) begin
    if (i_reset | i_clear) begin
      state <= duc_pkg::IDLE;
      count <= '0;
    end else begin
      if (take_in) begin
        state <= duc_pkg::HOLD;
        count <= factor;
      end else if (rep_done) begin
        if (last_rep) begin
          state <= duc_pkg::IDLE;
        end
        count <= count - duc_pkg::interp_t'(1);
      end
    end
  end

  // Held sample
  always_ff @(posedge ce_clk) begin
    if (take_in) begin
      hold_q <= i_tdata;
    end
  end

endmodule

/* verilog/duc_regs.sv */
//////////////////////////////////////////////////
// APB slave for the DUC settings
// Zero wait states, drives the chain configuration
//////////////////////////////////////////////////

module duc_regs (
  input  logic                i_clk_ce,
  input  logic                i_reset,
  // APB
  input  logic                i_psel,
  input  logic                i_penable,
  input  logic                i_pwrite,
  input  duc_pkg::apb_addr_t  i_paddr,
  input  logic [31:0]         i_pwdata,
  output logic [31:0]         o_prdata,
  output logic                o_pready,
  output logic                o_pslverr,
  // Settings to the chain
  output duc_pkg::phase_t     o_phase_inc,
  output duc_pkg::scale_t     o_scale,
  output duc_pkg::interp_t    o_interp,
  output logic                o_clear
);

  localparam duc_pkg::scale_t SCALE_UNITY = 16'd16384;

  logic access;
  logic wr_en;
  logic addr_mapped;
  logic id_write;

  // Access phase of a transfer
  assign access = i_psel & i_penable;
  assign wr_en  = access & i_pwrite;

  always_comb begin
    case (i_paddr)
      duc_pkg::REG_PHASE_INC,
      duc_pkg::REG_SCALE,
      duc_pkg::REG_INTERP,
      duc_pkg::REG_CLEAR,
      duc_pkg::REG_ID:   addr_mapped = 1'b1;
      default:           addr_mapped = 1'b0;
    endcase
  end

  // ID is read-only
  assign id_write  = wr_en & (i_paddr == duc_pkg::REG_ID);
  assign o_pslverr = access & (~addr_mapped | id_write);
  assign o_pready  = 1'b1;

  //////////////////////////////////////////////////
  // Setting registers
  //////////////////////////////////////////////////

  always_ff @(posedge i_clk_ce) begin
    if (i_reset) begin
      o_phase_inc <= '0;
      o_scale     <= SCALE_UNITY;
      o_interp    <= '0;
      o_clear     <= 1'b0;
    end else begin
      o_clear <= wr_en & (i_paddr == duc_pkg::REG_CLEAR) & i_pwdata[0];
      if (wr_en) begin
        case (i_paddr)
          duc_pkg::REG_PHASE_INC: o_phase_inc <= i_pwdata;
          duc_pkg::REG_SCALE:     o_scale     <= i_pwdata[15:0];
          duc_pkg::REG_INTERP:    o_interp    <= i_pwdata[7:0];
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // Readback
  //////////////////////////////////////////////////

  // Clear and unmapped offsets read as zero
  always_comb begin
    case (i_paddr)
      duc_pkg::REG_PHASE_INC: o_prdata = o_phase_inc;
      duc_pkg::REG_SCALE:     o_prdata = {16'd0, o_scale};
      duc_pkg::REG_INTERP:    o_prdata = {24'd0, o_interp};
      duc_pkg::REG_ID:        o_prdata = duc_pkg::DUC_ID;
      default:                o_prdata = 32'd0;
    endcase
  end

endmodule

/* common/duc_pkg.sv */
//////////////////////////////////////////////////
// Shared types and register map for the DUC block
// Referenced by scoped name from every module
//////////////////////////////////////////////////

package duc_pkg;

  //////////////////////////////////////////////////
  // Sample path types
  //////////////////////////////////////////////////

  // Complex sample, I in the upper half, Q in the lower half
  typedef logic [31:0] sample_t;

  // One signed I or Q component
  typedef logic signed [15:0] comp_t;

  // NCO phase accumulator and phase increment
  typedef logic [31:0] phase_t;

  // Unsigned gain, 16384 is unity
  typedef logic [15:0] scale_t;

  // Repeat count per input sample, 0 acts as 1
  typedef logic [7:0] interp_t;

  //////////////////////////////////////////////////
  // Control types
  //////////////////////////////////////////////////

  typedef logic [7:0] apb_addr_t;

  // Interpolator FSM
  typedef enum logic [1:0] {
    IDLE,
    HOLD
  } interp_state_t;

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////

  localparam apb_addr_t REG_PHASE_INC = 8'h00;
  localparam apb_addr_t REG_SCALE     = 8'h04;
  localparam apb_addr_t REG_INTERP    = 8'h08;
  // Write-only, bit 0 fires a one-cycle clear
  localparam apb_addr_t REG_CLEAR     = 8'h0C;
  localparam apb_addr_t REG_ID        = 8'h10;

  // Read-only block identifier
  localparam logic [31:0] DUC_ID = 32'hD0C0_0001;

  // Entries in one full sine period
  localparam int LUT_DEPTH = 64;

endpackage

/* common/duc_sine_lut.svh */
//////////////////////////////////////////////////
// One full period of signed 16-bit sine samples
// Included inside the NCO module body
//////////////////////////////////////////////////

`ifndef DUC_SINE_LUT_SVH
`define DUC_SINE_LUT_SVH

// Entry k holds round(32767 * sin(2*pi*k/64))
// Cosine reads the same table a quarter period ahead
localparam duc_pkg::comp_t SINE_LUT [duc_pkg::LUT_DEPTH] = '{
  // First quadrant
  0,      3212,   6393,   9512,
  12539,  15446,  18204,  20787,
  23170,  25329,  27245,  28898,
  30273,  31356,  32137,  32609,
  // Second quadrant
  32767,  32609,  32137,  31356,
  30273,  28898,  27245,  25329,
  23170,  20787,  18204,  15446,
  12539,  9512,   6393,   3212,
  // Third quadrant
  0,      -3212,  -6393,  -9512,
  -12539, -15446, -18204, -20787,
  -23170, -25329, -27245, -28898,
  -30273, -31356, -32137, -32609,
  // Fourth quadrant
  -32767, -32609, -32137, -31356,
  -30273, -28898, -27245, -25329,
  -23170, -20787, -18204, -15446,
  -12539, -9512,  -6393,  -3212
};

`endif
